/* Makefile */
# Verilator simulation of the 24 to 32 bit stream resizer

VERILATOR ?= verilator
TOP       ?= axis_resize_tb
FILELIST  ?= axis_resize.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ps

.PHONY: sim clean

# build, run, then decide the result from the log
sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR) -o $(TOP)
	./$(BUILD_DIR)/$(TOP) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "TB FAILED" $(LOG); then echo "simulation reported failure"; exit 1; fi
	@if ! grep -q "TB PASSED" $(LOG); then echo "simulation ended early"; exit 1; fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* axis_resize.f */
common/axis_pkg.sv
rtl/axis_reg_slice.sv
axis_resize/axis_upsizer.sv
axis_resize/axis_downsizer.sv
axis_resize/axis_width_converter.sv
rtl/axis_resize_top.sv
tb/axis_resize_chk.sv
tb/axis_resize_tb.sv

/* axis_resize/axis_downsizer.sv */
// ********************
// axis_downsizer
// splits each wide word into DOWN output beats,
// lowest group first
// ********************
`default_nettype none
`timescale 1ns/1ps

module axis_downsizer #(
  parameter int DOWN = axis_pkg::down_ratio
) (
  input  wire logic                 clk,
  input  wire logic                 reset,

  input  wire axis_pkg::wide_beat_t in_beat,
  input  wire logic                 in_valid,
  output logic                      in_ready,

  output axis_pkg::out_beat_t       out_beat,
  output logic                      out_valid,
  input  wire logic                 out_ready
);

  localparam int wide_w = $bits(in_beat.data);
  localparam int out_w = $bits(out_beat.data);
  localparam int sub_per_out = out_w / axis_pkg::sub_width;
  localparam int sub_per_wide = wide_w / axis_pkg::sub_width;
  localparam int cnt_w = (DOWN > 1) ? $clog2(DOWN) : 1;
  localparam logic [cnt_w-1:0] last_group = cnt_w'(DOWN - 1);

  if (sub_per_wide != DOWN * sub_per_out) begin : g_ratio_check
    $error("axis_downsizer: wide word does not split into DOWN beats");
  end

  logic [wide_w-1:0] hold_data;
  logic              hold_last;
  logic              hold_valid;
  logic [cnt_w-1:0]  cnt;
  logic              final_group;
  logic              out_accept;
  logic              in_accept;

  assign final_group = (cnt == last_group);
  assign out_accept  = hold_valid && out_ready;

  // a new word may only enter as the last group of the old one leaves
  assign in_ready  = !hold_valid || (out_ready && final_group);
  assign in_accept = in_valid && in_ready;

  // the current group always sits in the low bits of the hold register
  assign out_valid     = hold_valid;
  assign out_beat.data = hold_data[out_w-1:0];
  assign out_beat.last = hold_last && final_group;

  // group counter and word occupancy
  always_ff @(posedge clk) begin
    if (reset) begin
      hold_valid <= 1'b0;
      cnt        <= '0;
    end else begin
      if (in_accept) begin
        hold_valid <= 1'b1;
        cnt        <= '0;
      end else if (out_accept) begin
        if (final_group) begin
          hold_valid <= 1'b0;
          cnt        <= '0;
        end else begin
          cnt <= cnt + 1'b1;
        end
      end
    end
  end

  // load a fresh word or shift the next group down
  always_ff @(posedge clk) begin
    if (in_accept) begin
      hold_data <= in_beat.data;
      hold_last <= in_beat.last;
    end else if (out_accept) begin
      hold_data <= hold_data >> out_w;
    end
  end

endmodule

`default_nettype wire

/* axis_resize/axis_upsizer.sv */
// ********************
// axis_upsizer
// gathers UP narrow beats into one wide word,
// a beat with last flushes a partial word
// ********************
`default_nettype none
`timescale 1ns/1ps

module axis_upsizer #(
  parameter int UP = axis_pkg::up_ratio
) (
  input  wire logic                  clk,
  input  wire logic                  reset,

  input  wire axis_pkg::narrow_beat_t in_beat,
  input  wire logic                  in_valid,
  output logic                       in_ready,

  output axis_pkg::wide_beat_t       out_beat,
  output logic                       out_valid,
  input  wire logic                  out_ready
);

  localparam int in_w = $bits(in_beat.data);
  localparam int wide_w = $bits(out_beat.data);
  localparam int sub_per_in = in_w / axis_pkg::sub_width;
  localparam int sub_per_wide = wide_w / axis_pkg::sub_width;
  localparam int cnt_w = (UP > 1) ? $clog2(UP) : 1;
  localparam logic [cnt_w-1:0] last_slot = cnt_w'(UP - 1);

  // the beat types have to agree with the ratio
  if (sub_per_wide != UP * sub_per_in) begin : g_ratio_check
    $error("axis_upsizer: wide word does not hold UP narrow beats");
  end

  logic [cnt_w-1:0]  cnt;
  logic [wide_w-1:0] gather_data;
  logic [wide_w-1:0] packed_data;
  logic              completes;
  logic              out_free;
  logic              accept;

  // word ends on the last slot or on a packet boundary
  assign completes = (cnt == last_slot) || in_beat.last;
  assign out_free  = !out_valid || out_ready;

  // partial words keep gathering while the output waits
  assign in_ready = out_free || !completes;
  assign accept   = in_valid && in_ready;

  // slots below cnt come from the gather register, the current beat fills
  // slot cnt and everything above it is zero padding
  always_comb begin
    for (int i = 0; i < UP; i++) begin
      if (i < int'(cnt)) begin
        packed_data[i*in_w +: in_w] = gather_data[i*in_w +: in_w];
      end else if (i == int'(cnt)) begin
        packed_data[i*in_w +: in_w] = in_beat.data;
      end else begin
        packed_data[i*in_w +: in_w] = '0;
      end
    end
  end

  // slot counter and output valid
  always_ff @(posedge clk) begin
    if (reset) begin
      cnt       <= '0;
      out_valid <= 1'b0;
    end else begin
      if (out_valid && out_ready) begin
        out_valid <= 1'b0;
      end
      if (accept) begin
        if (completes) begin
          cnt       <= '0;
          out_valid <= 1'b1;
        end else begin
          cnt <= cnt + 1'b1;
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    if (accept) begin
      gather_data[cnt*in_w +: in_w] <= in_beat.data;
      if (completes) begin
        out_beat.data <= packed_data;
        out_beat.last <= in_beat.last;
      end
    end
  end

endmodule

`default_nettype wire

/* axis_resize/axis_width_converter.sv */
// ********************
// axis_width_converter
// rational UP:DOWN stream converter built from
// an upsizer into a downsizer over one wide link
// ********************
`default_nettype none
`timescale 1ns/1ps

module axis_width_converter #(
  parameter int UP   = axis_pkg::up_ratio,
  parameter int DOWN = axis_pkg::down_ratio
) (
  input  wire logic                  clk,
  input  wire logic                  reset,

  input  wire axis_pkg::narrow_beat_t in_beat,
  input  wire logic                  in_valid,
  output logic                       in_ready,

  output axis_pkg::out_beat_t        out_beat,
  output logic                       out_valid,
  input  wire logic                  out_ready
);

  // wide link between the two halves
  axis_pkg::wide_beat_t wide_beat;
  logic                 wide_valid;
  logic                 wide_ready;

  axis_upsizer #(
    .UP(UP)
  ) i_upsizer (
    .clk       (clk),
    .reset     (reset),
    .in_beat   (in_beat),
    .in_valid  (in_valid),
    .in_ready  (in_ready),
    .out_beat  (wide_beat),
    .out_valid (wide_valid),
    .out_ready (wide_ready)
  );

  axis_downsizer #(
    .DOWN(DOWN)
  ) i_downsizer (
    .clk       (clk),
    .reset     (reset),
    .in_beat   (wide_beat),
    .in_valid  (wide_valid),
    .in_ready  (wide_ready),
    .out_beat  (out_beat),
    .out_valid (out_valid),
    .out_ready (out_ready)
  );

endmodule

`default_nettype wire

/* common/axis_pkg.sv */
// ********************
// axis_pkg
// stream widths, ratios and beat structs
// for the 24 to 32 bit width converter
// ********************
`default_nettype none

package axis_pkg;

  // data moves in byte-wide subwords, lowest first
  parameter int sub_width = 8;
  parameter int in_width = 24;

  // narrow beats and output beats per wide word
  parameter int up_ratio = 4;
  parameter int down_ratio = 3;

  parameter int wide_width = in_width * up_ratio;
  parameter int out_width = wide_width / down_ratio;

  typedef struct packed {
    logic [in_width-1:0] data;
    logic                last;
  } narrow_beat_t;

  typedef struct packed {
    logic [wide_width-1:0] data;
    logic                  last;
  } wide_beat_t;

  typedef struct packed {
    logic [out_width-1:0] data;
    logic                 last;
  } out_beat_t;

endpackage

`default_nettype wire

/* rtl/axis_reg_slice.sv */
// ********************
// axis_reg_slice
// one-entry stream register slice that breaks
// the valid/data path at full throughput
// ********************
`default_nettype none
`timescale 1ns/1ps

module axis_reg_slice #(
  parameter type payload_t = logic
) (
  input  wire logic     clk,
  input  wire logic     reset,

  // upstream side
  input  wire payload_t in_beat,
  input  wire logic     in_valid,
  output logic          in_ready,

  // downstream side
  output payload_t      out_beat,
  output logic          out_valid,
  input  wire logic     out_ready
);

  logic in_accept;
  logic out_accept;

  // the held beat leaves in the same cycle a new one may enter
  assign out_accept = out_valid && out_ready;
  assign in_ready   = !out_valid || out_ready;
  assign in_accept  = in_valid && in_ready;

  // occupancy flag
  always_ff @(posedge clk) begin
    if (reset) begin
      out_valid <= 1'b0;
    end else begin
      if (in_accept) begin
        out_valid <= 1'b1;
      end else if (out_accept) begin
        out_valid <= 1'b0;
      end
    end
  end

  // payload is loaded only on an accepted beat
  always_ff @(posedge clk) begin
    if (in_accept) begin
      out_beat <= in_beat;
    end
  end

endmodule

`default_nettype wire

/* rtl/axis_resize_top.sv */
// ********************
// axis_resize_top
// 24 to 32 bit stream resizer with register
// slices on both edges
// ********************
`default_nettype none
`timescale 1ns/1ps

module axis_resize_top #(
  parameter int UP   = axis_pkg::up_ratio,
  parameter int DOWN = axis_pkg::down_ratio
) (
  input  wire logic                  clk,
  input  wire logic                  reset,

  input  wire axis_pkg::narrow_beat_t in_beat,
  input  wire logic                  in_valid,
  output logic                       in_ready,

  output axis_pkg::out_beat_t        out_beat,
  output logic                       out_valid,
  input  wire logic                  out_ready
);

  axis_pkg::narrow_beat_t cv_in_beat;
  logic                   cv_in_valid;
  logic                   cv_in_ready;
  axis_pkg::out_beat_t    cv_out_beat;
  logic                   cv_out_valid;
  logic                   cv_out_ready;

  axis_reg_slice #(
    .payload_t(axis_pkg::narrow_beat_t)
  ) i_in_slice (
    .clk       (clk),
    .reset     (reset),
    .in_beat   (in_beat),
    .in_valid  (in_valid),
    .in_ready  (in_ready),
    .out_beat  (cv_in_beat),
    .out_valid (cv_in_valid),
    .out_ready (cv_in_ready)
  );

  axis_width_converter #(
    .UP   (UP),
    .DOWN (DOWN)
  ) i_converter (
    .clk       (clk),
    .reset     (reset),
    .in_beat   (cv_in_beat),
    .in_valid  (cv_in_valid),
    .in_ready  (cv_in_ready),
    .out_beat  (cv_out_beat),
    .out_valid (cv_out_valid),
    .out_ready (cv_out_ready)
  );

  axis_reg_slice #(
    .payload_t(axis_pkg::out_beat_t)
  ) i_out_slice (
    .clk       (clk),
    .reset     (reset),
    .in_beat   (cv_out_beat),
    .in_valid  (cv_out_valid),
    .in_ready  (cv_out_ready),
    .out_beat  (out_beat),
    .out_valid (out_valid),
    .out_ready (out_ready)
  );

endmodule

`default_nettype wire

/* tb/axis_resize_chk.sv */
// ********************
// axis_resize_chk
// handshake assertions bound to the resizer top
// ********************
`default_nettype none
`timescale 1ns/1ps

module axis_resize_chk (
  input wire logic                clk,
  input wire logic                reset,
  input wire logic                in_ready,
  input wire axis_pkg::out_beat_t out_beat,
  input wire logic                out_valid,
  input wire logic                out_ready
);

  int failures = 0;

  // reset empties the output slice
  property p_idle_after_reset;
    @(posedge clk) reset |=> !out_valid;
  endproperty

  // a stalled output beat stays put
  property p_hold_on_stall;
    @(posedge clk) disable iff (reset)
      (out_valid && !out_ready) |=> (out_valid && $stable(out_beat));
  endproperty

  // the empty input slice takes data right after reset
  property p_ready_after_reset;
    @(posedge clk) reset |=> in_ready;
  endproperty

  a_idle_after_reset: assert property (p_idle_after_reset)
    else begin
      $error("out_valid high in the cycle after reset");
      failures++;
    end
  a_hold_on_stall: assert property (p_hold_on_stall)
    else begin
      $error("output beat changed or dropped while out_ready was low");
      failures++;
    end
  a_ready_after_reset: assert property (p_ready_after_reset)
    else begin
      $error("in_ready low in the cycle after reset");
      failures++;
    end

endmodule

bind axis_resize_top axis_resize_chk i_chk (
  .clk       (clk),
  .reset     (reset),
  .in_ready  (in_ready),
  .out_beat  (out_beat),
  .out_valid (out_valid),
  .out_ready (out_ready)
);

`default_nettype wire

/* tb/axis_resize_tb.sv */
// ********************
// axis_resize_tb
// random packets through the resizer, checked
// against a subword model of the padding rule
// ********************
`default_nettype none
`timescale 1ns/1ps

module axis_resize_tb;

  localparam int sub_w = axis_pkg::sub_width;
  localparam int sub_per_in = axis_pkg::in_width / sub_w;
  localparam int sub_per_wide = axis_pkg::wide_width / sub_w;
  localparam int sub_per_out = axis_pkg::out_width / sub_w;
  localparam int accept_limit = 500;
  localparam int drain_limit = 5000;

  typedef logic [axis_pkg::in_width-1:0] in_word_q_t[$];
  typedef axis_pkg::out_beat_t out_beat_q_t[$];

  logic                   clk;
  logic                   reset;
  axis_pkg::narrow_beat_t in_beat;
  logic                   in_valid;
  logic                   in_ready;
  axis_pkg::out_beat_t    out_beat;
  logic                   out_valid;
  logic                   out_ready;

  int          seed = 32'h56e1;
  int          ready_seed;
  int          ready_pct;
  int          errors;
  int          compared;
  int          packets_sent;
  int          lasts_seen;
  string       cur_test;
  out_beat_q_t exp_q;
  out_beat_q_t got_q;
  int          exp_count_q[$];

  axis_resize_top #(
    .UP   (axis_pkg::up_ratio),
    .DOWN (axis_pkg::down_ratio)
  ) i_dut (
    .clk       (clk),
    .reset     (reset),
    .in_beat   (in_beat),
    .in_valid  (in_valid),
    .in_ready  (in_ready),
    .out_beat  (out_beat),
    .out_valid (out_valid),
    .out_ready (out_ready)
  );

  initial begin
    clk = 1'b0;
    forever begin
      #2 clk = ~clk;
    end
  end

  // expected output of one packet with bytes lowest first, zero padded to
  // whole wide words and regrouped into output beats with last on the final one
  function automatic out_beat_q_t model_packet(input in_word_q_t words);
    logic [sub_w-1:0]    subs[$];
    out_beat_q_t         beats;
    axis_pkg::out_beat_t b;
    foreach (words[i]) begin
      for (int s = 0; s < sub_per_in; s++) begin
        subs.push_back(words[i][s*sub_w +: sub_w]);
      end
    end
    while (subs.size() % sub_per_wide != 0) begin
      subs.push_back('0);
    end
    for (int k = 0; k < subs.size(); k += sub_per_out) begin
      b.data = '0;
      for (int s = 0; s < sub_per_out; s++) begin
        b.data[s*sub_w +: sub_w] = subs[k+s];
      end
      b.last = (k + sub_per_out == subs.size());
      beats.push_back(b);
    end
    return beats;
  endfunction

  function automatic int rand_below(input int n);
    return ($random(seed) & 32'h7fff_ffff) % n;
  endfunction

  task automatic stop_on_timeout(input string what);
    errors++;
    $display("TIMEOUT in %s: %s", cur_test, what);
    $display("errors: %0d, assertion failures: %0d, beats compared: %0d", errors,
             i_dut.i_chk.failures, compared);
    $display("TB FAILED");
    $finish;
  endtask

  // holds the beat until in_ready is seen mid-cycle
  task automatic send_beat(input logic [axis_pkg::in_width-1:0] data, input logic last,
                           input int gap_pct);
    int   waited;
    int   gap;
    logic accepted;
    waited = 0;
    accepted = 1'b0;
    gap = (rand_below(100) < gap_pct) ? rand_below(4) + 1 : 0;
    repeat (gap) begin
      @(posedge clk);
      #1;
    end
    in_beat.data = data;
    in_beat.last = last;
    in_valid = 1'b1;
    while (!accepted) begin
      @(negedge clk);
      if (in_ready) begin
        accepted = 1'b1;
      end else begin
        waited++;
        if (waited > accept_limit) begin
          stop_on_timeout("in_ready stayed low");
        end
      end
      @(posedge clk);
      #1;
    end
    in_valid = 1'b0;
  endtask

  task automatic send_packet(input int len, input int gap_pct);
    in_word_q_t  words;
    out_beat_q_t exp;
    logic [31:0] r;
    for (int i = 0; i < len; i++) begin
      r = $random(seed);
      words.push_back(r[axis_pkg::in_width-1:0]);
    end
    exp = model_packet(words);
    foreach (exp[i]) begin
      exp_q.push_back(exp[i]);
    end
    // each started group of UP input beats becomes DOWN output beats
    exp_count_q.push_back(((len + axis_pkg::up_ratio - 1) / axis_pkg::up_ratio) *
                          axis_pkg::down_ratio);
    packets_sent++;
    foreach (words[i]) begin
      send_beat(words[i], i == len - 1, gap_pct);
    end
  endtask

  task automatic wait_drain();
    int waited;
    waited = 0;
    while (exp_q.size() != 0) begin
      @(posedge clk);
      #1;
      waited++;
      if (waited > drain_limit) begin
        stop_on_timeout("expected output beats never arrived");
      end
    end
  endtask

  // output back-pressure
  initial begin
    ready_seed = seed ^ 32'h0000_0f0f;
    forever begin
      @(posedge clk);
      #1;
      out_ready = ((($random(ready_seed) & 32'h7fff_ffff) % 100) < ready_pct);
    end
  end

  // records accepted output beats
  initial begin
    forever begin
      @(negedge clk);
      if (out_valid && out_ready && !reset) begin
        got_q.push_back(out_beat);
        if (out_beat.last) begin
          lasts_seen++;
        end
      end
    end
  end

  // compares accepted beats with the model in order
  initial begin
    axis_pkg::out_beat_t got;
    axis_pkg::out_beat_t exp;
    int                  pkt_beats;
    int                  exp_beats;
    pkt_beats = 0;
    forever begin
      @(posedge clk);
      while (got_q.size() > 0) begin
        got = got_q.pop_front();
        pkt_beats++;
        assert (exp_q.size() != 0) else begin
          errors++;
          $display("unexpected output beat %h in %s", got.data, cur_test);
        end
        if (exp_q.size() != 0) begin
          exp = exp_q.pop_front();
          compared++;
          assert (got.data == exp.data) else begin
            errors++;
            $display("MISMATCH %s data expected %h actual %h", cur_test, exp.data, got.data);
          end
          assert (got.last == exp.last) else begin
            errors++;
            $display("MISMATCH %s last expected %b actual %b", cur_test, exp.last, got.last);
          end
        end
        // beat count of the packet that this last closes
        if (got.last) begin
          exp_beats = 0;
          if (exp_count_q.size() != 0) begin
            exp_beats = exp_count_q.pop_front();
          end
          assert (pkt_beats == exp_beats) else begin
            errors++;
            $display("MISMATCH %s beat_count expected %0d actual %0d", cur_test,
                     exp_beats, pkt_beats);
          end
          pkt_beats = 0;
        end
      end
    end
  end

  initial begin
    reset = 1'b1;
    in_valid = 1'b0;
    in_beat = '0;
    out_ready = 1'b1;
    ready_pct = 100;
    errors = 0;
    compared = 0;
    packets_sent = 0;
    lasts_seen = 0;
    cur_test = "reset";
    repeat (16) @(posedge clk);
    #1;
    reset = 1'b0;

    // full and partial wide words without stalls
    cur_test = "len_sweep";
    for (int len = 1; len <= 9; len++) begin
      send_packet(len, 0);
    end
    wait_drain();

    cur_test = "backpressure";
    ready_pct = 50;
    repeat (200) send_packet(rand_below(12) + 1, 0);
    wait_drain();

    cur_test = "gaps_and_backpressure";
    ready_pct = 60;
    repeat (100) send_packet(rand_below(12) + 1, 30);
    wait_drain();

    cur_test = "back_to_back";
    ready_pct = 100;
    send_packet(4, 0);
    send_packet(1, 0);
    send_packet(5, 0);
    send_packet(8, 0);
    send_packet(3, 0);
    wait_drain();

    // one wide word stuck at the output and two beats gathering when reset hits
    cur_test = "reset_mid_packet";
    ready_pct = 0;
    @(posedge clk);
    #1;
    for (int i = 0; i < 6; i++) begin
      send_beat(24'h100 * i + 24'h5a, 1'b0, 0);
    end
    reset = 1'b1;
    repeat (4) @(posedge clk);
    #1;
    reset = 1'b0;
    ready_pct = 100;
    for (int i = 0; i < 8; i++) begin
      @(negedge clk);
      assert (!out_valid) else begin
        errors++;
        $display("out_valid rose after reset with no new input");
      end
      assert (in_ready) else begin
        errors++;
        $display("in_ready low after reset");
      end
      @(posedge clk);
      #1;
    end
    send_packet(3, 0);
    wait_drain();

    // room for stray beats to show up
    repeat (20) @(posedge clk);
    assert (lasts_seen == packets_sent) else begin
      errors++;
      $display("MISMATCH packet_count expected %0d actual %0d", packets_sent, lasts_seen);
    end

    $display("errors: %0d, assertion failures: %0d, beats compared: %0d", errors,
             i_dut.i_chk.failures, compared);
    if (errors == 0 && i_dut.i_chk.failures == 0) begin
      $display("TB PASSED");
    end else begin
      $display("TB FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire
